// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;   // Register index width

    // One instruction walks through all six states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_FETCH     = 3'd1,
        ST_DECODE    = 3'd2,
        ST_EXECUTE   = 3'd3,
        ST_MEMORY    = 3'd4,
        ST_WRITEBACK = 3'd5
    } core_state_e;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic {
        SRC_A_PC,
        SRC_A_RS1
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM,
        SRC_B_FOUR  // Constant 4 for link address
    } src_b_e;

    // Source of the value written to rd
    typedef enum logic [2:0] {
        WB_ALU, WB_SLT, WB_SLTU, WB_MEM, WB_IMM, WB_LINK
    } wb_sel_e;

endpackage

`default_nettype wire

// File: rv_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Control from sequencer to datapath, levels and pulses only
interface rv_ctrl_if
    import rv_pkg::*;
();
    core_state_e     state;
    logic [XLEN-1:0] instr;      // Latched instruction word
    src_a_e          src_a;      // ALU operand A select
    src_b_e          src_b;      // ALU operand B select
    alu_op_e         alu_op;
    wb_sel_e         wb_sel;
    logic            reg_write;  // Pulse in WRITEBACK
    logic            mem_wren;   // Pulse in MEMORY, stores only
    logic            pc_load;    // Pulse in MEMORY
    logic            link_save;  // Capture ALU result for later writeback

    modport ctrl (
        output state, instr, src_a, src_b, alu_op, wb_sel,
        output reg_write, mem_wren, pc_load, link_save
    );

    modport dp (
        input state, instr, src_a, src_b, alu_op, wb_sel,
        input reg_write, mem_wren, pc_load, link_save
    );

endinterface

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  wire              clk,
    rv_ctrl_if.dp            ctrl,
    input  wire  [XLEN-1:0]  rd_data,
    output logic [XLEN-1:0]  rs1_data,
    output logic [XLEN-1:0]  rs2_data
);
    logic [XLEN-1:0]       regs [2**REG_ADDR_W];
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic                  wr_en;

    assign rs1_addr = ctrl.instr[19:15];
    assign rs2_addr = ctrl.instr[24:20];
    assign rd_addr  = ctrl.instr[11:7];
    assign wr_en    = ctrl.reg_write && (ctrl.state == ST_WRITEBACK) && (rd_addr != '0);

    always_ff @(posedge clk) begin
        if (wr_en) regs[rd_addr] <= rd_data;  // x0 never written
    end

    // Combinational reads, x0 reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen
    import rv_pkg::*;
(
    rv_ctrl_if.dp            ctrl,
    output logic [XLEN-1:0]  imm
);
    logic [XLEN-1:0] ir;
    opcode_e         opcode;

    assign ir     = ctrl.instr;
    assign opcode = opcode_e'(ir[6:0]);

    always_comb begin
        case (opcode)
            OPC_STORE:           // S format
                imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH:          // B format, bit 0 always zero
                imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:  // U format
                imm = {ir[31:12], 12'b0};
            OPC_JAL:             // J format
                imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default:
                // I format for OP_IMM, LOAD and JALR
                imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  wire              clk,
    rv_ctrl_if.dp            ctrl,
    input  wire  [XLEN-1:0]  pc,
    input  wire  [XLEN-1:0]  rs1_data,
    input  wire  [XLEN-1:0]  rs2_data,
    input  wire  [XLEN-1:0]  imm,
    input  wire  [XLEN-1:0]  mem_rdata,
    output logic [XLEN-1:0]  rd_data,
    output logic [XLEN-1:0]  alu_result,
    output logic             zero,
    output logic             lt,
    output logic             ltu
);
    logic [XLEN-1:0] op_a, op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] link_q;   // Saved PC + 4 or AUIPC sum

    assign op_a  = (ctrl.src_a == SRC_A_PC) ? pc : rs1_data;
    assign op_b  = (ctrl.src_b == SRC_B_RS2) ? rs2_data :
                   (ctrl.src_b == SRC_B_IMM) ? imm : XLEN'(4);
    assign shamt = op_b[4:0];  // Upper immediate bits ignored for shifts

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_SLL: alu_result = op_a << shamt;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SRL: alu_result = op_a >> shamt;
            ALU_SRA: alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:  alu_result = op_a | op_b;
            default: alu_result = op_a & op_b;
        endcase
    end

    // Flags for branches and set-less-than
    assign zero = (alu_result == '0);
    assign lt   = $signed(op_a) < $signed(op_b);
    assign ltu  = op_a < op_b;

    always_ff @(posedge clk) begin
        if (ctrl.link_save) link_q <= alu_result;
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_SLT:  rd_data = {{(XLEN-1){1'b0}}, lt};
            WB_SLTU: rd_data = {{(XLEN-1){1'b0}}, ltu};
            WB_MEM:  rd_data = mem_rdata;  // Word load
            WB_IMM:  rd_data = imm;        // LUI
            WB_LINK: rd_data = link_q;
            default: rd_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire              clk,
    input  wire              reset,
    rv_ctrl_if.dp            ctrl,
    input  wire  [XLEN-1:0]  imm,
    input  wire  [XLEN-1:0]  alu_result,
    input  wire              zero,
    input  wire              lt,
    input  wire              ltu,
    output logic [XLEN-1:0]  pc
);
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            take_branch;
    logic [XLEN-1:0] target;     // PC-relative for branches and JAL
    logic [XLEN-1:0] next_pc;

    assign opcode = opcode_e'(ctrl.instr[6:0]);
    assign funct3 = ctrl.instr[14:12];
    assign target = pc + imm;

    always_comb begin
        case (funct3)
            3'b000:  take_branch = zero;   // BEQ
            3'b001:  take_branch = !zero;  // BNE
            3'b100:  take_branch = lt;     // BLT
            3'b101:  take_branch = !lt;    // BGE
            3'b110:  take_branch = ltu;    // BLTU
            3'b111:  take_branch = !ltu;   // BGEU
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = pc + XLEN'(4);
        if (opcode == OPC_JAL || (opcode == OPC_BRANCH && take_branch))
            next_pc = target;
        else if (opcode == OPC_JALR)
            next_pc = {alu_result[XLEN-1:1], 1'b0};  // rs1 + imm with bit 0 cleared
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= RESET_PC;
        else if (ctrl.pc_load) pc <= next_pc;  // Edge into WRITEBACK
    end

endmodule

`default_nettype wire

// File: rv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rv_sequencer
    import rv_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire [XLEN-1:0]  imem_rdata,
    rv_ctrl_if.ctrl         ctrl
);
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt_bit;        // funct7 bit 5, or instr[30] for I-type shifts
    src_a_e     dec_src_a;
    src_b_e     dec_src_b;
    alu_op_e    dec_alu_op;
    wb_sel_e    dec_wb_sel;
    logic       dec_reg_write;
    logic       dec_store;
    logic       dec_link;       // Result kept in the link register
    logic       is_jump;

    // ALU operation from funct3, SUB only allowed on R-type
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        case (f3)
            3'b000:         arith_op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:         arith_op = ALU_SLL;
            3'b010, 3'b011: arith_op = ALU_SUB;  // SLT forms read the flags
            3'b100:         arith_op = ALU_XOR;
            3'b101:         arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:         arith_op = ALU_OR;
            default:        arith_op = ALU_AND;
        endcase
    endfunction

    function automatic wb_sel_e arith_wb(input logic [2:0] f3);
        case (f3)
            3'b010:  arith_wb = WB_SLT;
            3'b011:  arith_wb = WB_SLTU;
            default: arith_wb = WB_ALU;
        endcase
    endfunction

    assign opcode  = opcode_e'(ctrl.instr[6:0]);
    assign funct3  = ctrl.instr[14:12];
    assign alt_bit = ctrl.instr[30];
    assign is_jump = (opcode == OPC_JAL) || (opcode == OPC_JALR);

    // Final operand selects and strobes per opcode
    always_comb begin
        dec_src_a     = SRC_A_RS1;
        dec_src_b     = SRC_B_RS2;
        dec_alu_op    = ALU_ADD;
        dec_wb_sel    = WB_ALU;
        dec_reg_write = 1'b0;
        dec_store     = 1'b0;
        dec_link      = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_alu_op    = arith_op(funct3, alt_bit, 1'b1);
                dec_wb_sel    = arith_wb(funct3);
                dec_reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_src_b     = SRC_B_IMM;
                dec_alu_op    = arith_op(funct3, alt_bit, 1'b0);
                dec_wb_sel    = arith_wb(funct3);
                dec_reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec_src_b     = SRC_B_IMM;   // Address rs1 + imm
                dec_wb_sel    = WB_MEM;
                dec_reg_write = 1'b1;
            end
            OPC_STORE: begin
                dec_src_b = SRC_B_IMM;
                dec_store = 1'b1;
            end
            OPC_BRANCH: dec_alu_op = ALU_SUB;  // zero flag for BEQ/BNE
            OPC_JAL: begin
                dec_src_a     = SRC_A_PC;
                dec_src_b     = SRC_B_FOUR;
                dec_wb_sel    = WB_LINK;
                dec_reg_write = 1'b1;
                dec_link      = 1'b1;
            end
            OPC_JALR: begin
                dec_src_b     = SRC_B_IMM;   // Target rs1 + imm
                dec_wb_sel    = WB_LINK;
                dec_reg_write = 1'b1;
                dec_link      = 1'b1;
            end
            OPC_LUI: begin
                dec_wb_sel    = WB_IMM;
                dec_reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                dec_src_a     = SRC_A_PC;
                dec_src_b     = SRC_B_IMM;
                dec_wb_sel    = WB_LINK;     // PC moves before writeback so keep the sum
                dec_reg_write = 1'b1;
                dec_link      = 1'b1;
            end
            default: ;                       // Unknown opcode runs as a NOP
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.state == ST_FETCH) ctrl.instr <= imem_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.state     <= ST_IDLE;
            ctrl.src_a     <= SRC_A_PC;
            ctrl.src_b     <= SRC_B_FOUR;
            ctrl.alu_op    <= ALU_ADD;
            ctrl.wb_sel    <= WB_ALU;
            ctrl.reg_write <= 1'b0;
            ctrl.mem_wren  <= 1'b0;
            ctrl.pc_load   <= 1'b0;
            ctrl.link_save <= 1'b0;
        end else begin
            ctrl.reg_write <= 1'b0;  // All strobes are single-cycle
            ctrl.mem_wren  <= 1'b0;
            ctrl.pc_load   <= 1'b0;
            ctrl.link_save <= 1'b0;
            case (ctrl.state)
                ST_IDLE:  ctrl.state <= ST_FETCH;
                ST_FETCH: ctrl.state <= ST_DECODE;
                ST_DECODE: begin
                    // Jumps first compute PC + 4 for the link
                    ctrl.src_a     <= is_jump ? SRC_A_PC : dec_src_a;
                    ctrl.src_b     <= is_jump ? SRC_B_FOUR : dec_src_b;
                    ctrl.alu_op    <= is_jump ? ALU_ADD : dec_alu_op;
                    ctrl.wb_sel    <= dec_wb_sel;
                    ctrl.link_save <= dec_link;  // Held high through EXECUTE
                    ctrl.state     <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    ctrl.src_a    <= dec_src_a;
                    ctrl.src_b    <= dec_src_b;
                    ctrl.alu_op   <= dec_alu_op;
                    ctrl.mem_wren <= dec_store;
                    ctrl.pc_load  <= 1'b1;
                    ctrl.state    <= ST_MEMORY;
                end
                ST_MEMORY: begin
                    ctrl.reg_write <= dec_reg_write;
                    ctrl.state     <= ST_WRITEBACK;
                end
                default: ctrl.state <= ST_IDLE;  // WRITEBACK closes the instruction
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0  // First fetch address
) (
    input  wire              clk,
    input  wire              reset,
    output logic [XLEN-1:0]  imem_addr,
    input  wire  [XLEN-1:0]  imem_rdata,
    output logic [XLEN-1:0]  dmem_addr,
    output logic [XLEN-1:0]  dmem_wdata,
    output logic             dmem_wren,
    input  wire  [XLEN-1:0]  dmem_rdata
);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data, rs2_data;
    logic [XLEN-1:0] rd_data;     // Writeback value
    logic [XLEN-1:0] alu_result;
    logic            zero, lt, ltu;

    rv_ctrl_if ctrl_bus ();

    rv_sequencer i_seq (.clk, .reset, .imem_rdata, .ctrl(ctrl_bus.ctrl));

    rv_regfile i_regs (.clk, .ctrl(ctrl_bus.dp), .rd_data, .rs1_data, .rs2_data);

    rv_imm_gen i_imm (.ctrl(ctrl_bus.dp), .imm);

    rv_alu i_alu (
        .clk, .ctrl(ctrl_bus.dp), .pc, .rs1_data, .rs2_data, .imm,
        .mem_rdata(dmem_rdata), .rd_data, .alu_result, .zero, .lt, .ltu
    );

    rv_pc_unit #(.RESET_PC(RESET_PC)) i_pc (
        .clk, .reset, .ctrl(ctrl_bus.dp), .imm, .alu_result,
        .zero, .lt, .ltu, .pc
    );

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;     // Load and store address is rs1 + imm
    assign dmem_wdata = rs2_data;
    assign dmem_wren  = ctrl_bus.mem_wren;

endmodule

`default_nettype wire

// File: tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_wren;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [256];   // Word index from addr[9:2]
    logic [31:0] dmem [256];

    logic [31:0] exp_addr_q [$];  // Expected stores, in order
    logic [31:0] exp_data_q [$];
    logic [95:0] exp_name_q [$];

    int n_instr;          // Instructions to run, from the trace
    int cycles;           // Clock edges since reset release
    int value_errors;
    int other_errors;
    logic trace_loaded;

    rv_core #(.RESET_PC(RESET_PC)) i_dut (
        .clk, .reset, .imem_addr, .imem_rdata,
        .dmem_addr, .dmem_wdata, .dmem_wren, .dmem_rdata
    );

    always #4 clk = ~clk;  // 8 ns period

    // Error counts, then the verdict
    task automatic close_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Program words, expected stores and run length from the trace file
    task automatic load_trace();
        int            fd;
        int            code;
        logic [7:0]    tag;
        logic [31:0]   f_addr;
        logic [31:0]   f_data;
        logic [95:0]   f_name;
        logic [2047:0] skip_line;   // Rest of a comment line
        fd = $fopen("core_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open core_trace.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(skip_line, fd);    // Comment line
                end else if (tag == "I") begin
                    code = $fscanf(fd, "%h %h", f_addr, f_data);
                    if (code != 2) begin
                        other_errors++;
                        $display("Incomplete instruction record in the trace file");
                    end
                    imem[f_addr[9:2]] = f_data;
                end else if (tag == "S") begin
                    code = $fscanf(fd, "%h %h %s", f_addr, f_data, f_name);
                    if (code != 3) begin
                        other_errors++;
                        $display("Incomplete store record in the trace file");
                    end
                    exp_addr_q.push_back(f_addr);
                    exp_data_q.push_back(f_data);
                    exp_name_q.push_back(f_name);
                end else if (tag == "N") begin
                    code = $fscanf(fd, "%d", n_instr);
                    if (code != 1) begin
                        other_errors++;
                        $display("Unreadable instruction count in the trace file");
                    end
                end else begin
                    other_errors++;
                    $display("Unknown record type %s in the trace file", tag);
                    code = $fgets(skip_line, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // Memories answer from the arrays, updated 1 ns after the edge
    always @(posedge clk) begin
        if (!reset) cycles = cycles + 1;
        #1;
        imem_rdata = imem[imem_addr[9:2]];
        dmem_rdata = dmem[dmem_addr[9:2]];
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (cycles < 2) begin   // Reset, IDLE and FETCH of the first instruction
            if (imem_addr !== RESET_PC) begin
                value_errors++;
                $display("ERROR reset_pc: expected %h, actual %h", RESET_PC, imem_addr);
            end
            if (dmem_wren !== 1'b0) begin
                other_errors++;
                $display("Store strobe went high before the first fetch");
            end
        end
        if (!reset && imem_addr[1:0] !== 2'b00) begin
            other_errors++;
            $display("Fetch address %h is not word aligned", imem_addr);
        end
        if (!reset && dmem_wren === 1'b1) begin
            if (exp_addr_q.size() == 0) begin
                other_errors++;
                $display("Unexpected store of %h to address %h", dmem_wdata, dmem_addr);
            end else begin
                if (dmem_addr !== exp_addr_q[0]) begin
                    value_errors++;
                    $display("ERROR %0s address: expected %h, actual %h",
                             exp_name_q[0], exp_addr_q[0], dmem_addr);
                end
                if (dmem_wdata !== exp_data_q[0]) begin
                    value_errors++;
                    $display("ERROR %0s data: expected %h, actual %h",
                             exp_name_q[0], exp_data_q[0], dmem_wdata);
                end
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_name_q.pop_front());
            end
            dmem[dmem_addr[9:2]] = dmem_wdata;  // Later loads see the stored word
        end
    end

    // Watchdog, six cycles per instruction plus reset and slack
    initial begin
        wait (trace_loaded);
        #((n_instr * 6 + 60) * 8);
        other_errors++;
        if (exp_addr_q.size() != 0) begin
            $display("Timeout with %0d expected stores never seen", exp_addr_q.size());
        end else begin
            $display("Timeout before the program finished");
        end
        close_run();
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        imem_rdata   = '0;
        dmem_rdata   = '0;
        cycles       = 0;
        n_instr      = 0;
        value_errors = 0;
        other_errors = 0;
        trace_loaded = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd00d_0000 | (i * 4);  // Unwritten words hold their own address
        end
        load_trace();
        if (n_instr == 0) begin
            other_errors++;
            $display("Trace file gives no instruction count");
        end
        trace_loaded = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        // Run the full program so a stray store can still show up
        while (exp_addr_q.size() != 0 || cycles < n_instr * 6) begin
            @(negedge clk);
            #1;  // Store checks of this negedge are done
        end
        close_run();
    end

endmodule

`default_nettype wire

// File: sources.f
rv_pkg.sv
rv_ctrl_if.sv
rv_regfile.sv
rv_imm_gen.sv
rv_alu.sv
rv_pc_unit.sv
rv_sequencer.sv
rv_core.sv
tb_core.sv

// File: core_trace.txt
# I <byte address> <instruction>, S <address> <data> <test name>, N <instructions to run>
# Hex fields except N, which is decimal; S records in the order the stores must appear
# ALU register and immediate forms
I 00000000 00500093
I 00000004 ffd00113
I 00000008 002081b3
I 0000000c 00302023
I 00000010 40208233
I 00000014 00402223
I 00000018 001122b3
I 0000001c 00502423
I 00000020 00113333
I 00000024 00602623
I 00000028 40115393
I 0000002c 00702823
I 00000030 01c15413
I 00000034 00802a23
I 00000038 00409493
I 0000003c 0ff4c513
I 00000040 00a02c23
# LUI and AUIPC
I 00000044 123455b7
I 00000048 00b02e23
I 0000004c 00001617
I 00000050 02c02023
# Branches, taken one skips a store to 3fc, not-taken one falls into a marker store
I 00000054 00108463
I 00000058 3e102e23
I 0000005c 00208463
I 00000060 04102023
I 00000064 00209463
I 00000068 3e102e23
I 0000006c 00109463
I 00000070 04102223
I 00000074 00114463
I 00000078 3e102e23
I 0000007c 0020c463
I 00000080 04102423
I 00000084 0020d463
I 00000088 3e102e23
I 0000008c 00115463
I 00000090 04102623
I 00000094 0020e463
I 00000098 3e102e23
I 0000009c 00116463
I 000000a0 04102823
I 000000a4 00117463
I 000000a8 3e102e23
I 000000ac 0020f463
I 000000b0 04102a23
# JAL and JALR with link, JALR target d0 + 1
I 000000b4 008006ef
I 000000b8 3e102e23
I 000000bc 04d02c23
I 000000c0 0d000793
I 000000c4 00178767
I 000000c8 3e102e23
I 000000cc 3e102e23
I 000000d0 04e02e23
# Store, load back, store again, then spin
I 000000d4 08902023
I 000000d8 08002803
I 000000dc 09002223
I 000000e0 0000006f
S 00000000 00000002 add
S 00000004 00000008 sub
S 00000008 00000001 slt
S 0000000c 00000000 sltu
S 00000010 fffffffe srai
S 00000014 0000000f srli
S 00000018 000000af slli_xori
S 0000001c 12345000 lui
S 00000020 0000104c auipc
S 00000040 00000005 beq
S 00000044 00000005 bne
S 00000048 00000005 blt
S 0000004c 00000005 bge
S 00000050 00000005 bltu
S 00000054 00000005 bgeu
S 00000058 000000b8 jal
S 0000005c 000000c8 jalr
S 00000080 00000050 sw_word
S 00000084 00000050 lw_word
N 50
